// ==== include/prf_config.svh ====
// ##########################################################################
// physical register file datapath sizes
// register count, zero register tag, data and tag widths
// ##########################################################################

`ifndef PRF_CONFIG_SVH
`define PRF_CONFIG_SVH

`define NUM_PR  32  // physical registers
`define ZERO_PR 31  // read-only zero register tag
`define XLEN    64  // datapath width
`define TAG_W   5   // physical tag width

`endif

// ==== source/prf_pkg.sv ====
// ##########################################################################
// shared types for the physical register file datapath
// alu operation codes and the two-layout issue word
// ##########################################################################

`default_nettype none

`include "prf_config.svh"

package prf_pkg;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,  // signed compare
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_t;

  // register-register layout
  typedef struct packed {
    alu_op_t            op;
    logic               is_imm;  // low here
    logic               word;    // 32-bit op, result sign-extended
    logic [`TAG_W-1:0]  dest;
    logic [`TAG_W-1:0]  src1;
    logic [`TAG_W-1:0]  src2;
    logic [32-6-3*`TAG_W-1:0] unused;
  } reg_form_t;

  // register-immediate layout, imm replaces src2
  typedef struct packed {
    alu_op_t            op;
    logic               is_imm;  // high here
    logic               word;
    logic [`TAG_W-1:0]  dest;
    logic [`TAG_W-1:0]  src1;
    logic [15:0]        imm;     // sign-extended in decode
  } imm_form_t;

  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } issue_word_u;

endpackage

`default_nettype wire

// ==== source/issue_decode.sv ====
// ##########################################################################
// issue decode stage
// splits a renamed issue word into op, tags and immediate, then registers
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "prf_config.svh"

module issue_decode (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       en,
  input  wire                       issue_valid,
  input  wire prf_pkg::issue_word_u issue_word,
  output logic                      dec_valid,
  output prf_pkg::alu_op_t          dec_op,
  output logic                      dec_word,
  output logic                      dec_use_imm,
  output logic [`TAG_W-1:0]         dec_dest,
  output logic [`TAG_W-1:0]         dec_src1,
  output logic [`TAG_W-1:0]         dec_src2,
  output logic [`XLEN-1:0]          dec_imm
);

  logic              use_imm;  // view select
  logic [`TAG_W-1:0] src2_next;
  logic [`XLEN-1:0]  imm_next;

  assign use_imm = issue_word.reg_form.is_imm;  // same bit in both views

  always_comb begin
    if (use_imm) begin
      src2_next = '0;  // unused, reads tag 0 harmlessly
      imm_next  = {{(`XLEN-16){issue_word.imm_form.imm[15]}}, issue_word.imm_form.imm};
    end else begin
      src2_next = issue_word.reg_form.src2;
      imm_next  = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (en) begin
      dec_valid <= issue_valid;  // bubble when nothing issued
    end
  end

  // payload only, loads on an accepted word
  always_ff @(posedge clock) begin
    if (en && issue_valid) begin
      dec_op      <= issue_word.reg_form.op;
      dec_word    <= issue_word.reg_form.word;
      dec_use_imm <= use_imm;
      dec_dest    <= issue_word.reg_form.dest;
      dec_src1    <= issue_word.reg_form.src1;
      dec_src2    <= src2_next;
      dec_imm     <= imm_next;
    end
  end

  a_dec_valid_known: assert property (
    @(posedge clock) disable iff (reset) !$isunknown(dec_valid)
  );

endmodule

`default_nettype wire

// ==== source/phys_regfile.sv ====
// ##########################################################################
// physical register file
// cdb write-back, hardwired zero register, two forwarded read ports
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "prf_config.svh"

module phys_regfile (
  input  wire                clock,
  input  wire                reset,
  input  wire                en,
  input  wire                cdb_valid,
  input  wire [`TAG_W-1:0]   cdb_tag,
  input  wire [`XLEN-1:0]    cdb_value,
  input  wire [`TAG_W-1:0]   dec_src1,
  input  wire [`TAG_W-1:0]   dec_src2,
  output logic [`XLEN-1:0]   src1_value,
  output logic [`XLEN-1:0]   src2_value
);

  logic [`XLEN-1:0] pr [`NUM_PR];  // register storage
  logic             cdb_write;     // broadcast targets a writable reg
  logic             fwd1;
  logic             fwd2;

  assign cdb_write = cdb_valid && (cdb_tag != `TAG_W'(`ZERO_PR));

  // bypass the broadcast being written this cycle
  assign fwd1 = cdb_write && (cdb_tag == dec_src1);
  assign fwd2 = cdb_write && (cdb_tag == dec_src2);

  assign src1_value = fwd1 ? cdb_value : pr[dec_src1];
  assign src2_value = fwd2 ? cdb_value : pr[dec_src2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_PR; i++) begin
        pr[i] <= '0;  // all regs read zero after reset
      end
    end else if (en && cdb_write) begin
      pr[cdb_tag] <= cdb_value;
    end
  end

  // the zero tag reads as zero through either port
  a_zero_read1: assert property (
    @(posedge clock) disable iff (reset)
      (dec_src1 == `TAG_W'(`ZERO_PR)) |-> (src1_value == '0)
  );

  a_zero_read2: assert property (
    @(posedge clock) disable iff (reset)
      (dec_src2 == `TAG_W'(`ZERO_PR)) |-> (src2_value == '0)
  );

endmodule

`default_nettype wire

// ==== source/alu_execute.sv ====
// ##########################################################################
// execute stage
// single 64-bit alu with word forms, result registered with its tag
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "prf_config.svh"

module alu_execute (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   en,
  input  wire                   dec_valid,
  input  wire prf_pkg::alu_op_t dec_op,
  input  wire                   dec_word,
  input  wire                   dec_use_imm,
  input  wire [`TAG_W-1:0]      dec_dest,
  input  wire [`XLEN-1:0]       dec_imm,
  input  wire [`XLEN-1:0]       src1_value,
  input  wire [`XLEN-1:0]       src2_value,
  output logic                  ex_valid,
  output logic [`TAG_W-1:0]     ex_dest,
  output logic                  ex_word,
  output logic [`XLEN-1:0]      ex_value
);

  logic [`XLEN-1:0] opb;      // second operand
  logic [5:0]       shamt;
  logic [`XLEN-1:0] srl_src;  // word srl sees only low half
  logic [`XLEN-1:0] result;

  assign opb     = dec_use_imm ? dec_imm : src2_value;
  assign shamt   = dec_word ? {1'b0, opb[4:0]} : opb[5:0];
  assign srl_src = dec_word ? {{(`XLEN-32){1'b0}}, src1_value[31:0]} : src1_value;

  always_comb begin
    case (dec_op)
      prf_pkg::ALU_ADD: result = src1_value + opb;
      prf_pkg::ALU_SUB: result = src1_value - opb;
      prf_pkg::ALU_AND: result = src1_value & opb;
      prf_pkg::ALU_OR:  result = src1_value | opb;
      prf_pkg::ALU_XOR: result = src1_value ^ opb;
      prf_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(src1_value) < $signed(opb)};
      prf_pkg::ALU_SLL: result = src1_value << shamt;
      prf_pkg::ALU_SRL: result = srl_src >> shamt;
      default:          result = '0;  // unused encodings
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (en) begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (en && dec_valid) begin
      ex_dest  <= dec_dest;
      ex_word  <= dec_word;  // sign-extension done in result stage
      ex_value <= result;
    end
  end

endmodule

`default_nettype wire

// ==== source/cdb_result.sv ====
// ##########################################################################
// result stage
// word sign-extension and the registered common data bus broadcast
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "prf_config.svh"

module cdb_result (
  input  wire                clock,
  input  wire                reset,
  input  wire                en,
  input  wire                ex_valid,
  input  wire [`TAG_W-1:0]   ex_dest,
  input  wire                ex_word,
  input  wire [`XLEN-1:0]    ex_value,
  output logic               cdb_valid,
  output logic [`TAG_W-1:0]  cdb_tag,
  output logic [`XLEN-1:0]   cdb_value
);

  logic [`XLEN-1:0] fmt_value;  // formatted result

  assign fmt_value = ex_word ? {{(`XLEN-32){ex_value[31]}}, ex_value[31:0]} : ex_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else if (en) begin
      cdb_valid <= ex_valid;  // held across stalls
    end
  end

  always_ff @(posedge clock) begin
    if (en && ex_valid) begin
      cdb_tag   <= ex_dest;
      cdb_value <= fmt_value;
    end
  end

  // a broadcast only follows an enabled cycle with a valid result
  a_cdb_from_ex: assert property (
    @(posedge clock) disable iff (reset) ($past(en) && cdb_valid) |-> $past(ex_valid)
  );

endmodule

`default_nettype wire

// ==== source/prf_core_top.sv ====
// ##########################################################################
// physical register file datapath top
// decode, register read, execute and cdb result, cdb exposed as outputs
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "prf_config.svh"

module prf_core_top (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       en,           // global stall when low
  input  wire                       issue_valid,
  input  wire prf_pkg::issue_word_u issue_word,
  output logic                      cdb_valid,
  output logic [`TAG_W-1:0]         cdb_tag,
  output logic [`XLEN-1:0]          cdb_value
);

  logic             dec_valid;
  prf_pkg::alu_op_t dec_op;
  logic             dec_word;
  logic             dec_use_imm;
  logic [`TAG_W-1:0] dec_dest;
  logic [`TAG_W-1:0] dec_src1;
  logic [`TAG_W-1:0] dec_src2;
  logic [`XLEN-1:0] dec_imm;
  logic [`XLEN-1:0] src1_value;  // forwarded reads
  logic [`XLEN-1:0] src2_value;
  logic             ex_valid;
  logic [`TAG_W-1:0] ex_dest;
  logic             ex_word;
  logic [`XLEN-1:0] ex_value;

  issue_decode u_decode (
    .clock, .reset, .en,
    .issue_valid, .issue_word,
    .dec_valid, .dec_op, .dec_word, .dec_use_imm,
    .dec_dest, .dec_src1, .dec_src2, .dec_imm
  );

  phys_regfile u_regfile (
    .clock, .reset, .en,
    .cdb_valid, .cdb_tag, .cdb_value,  // write-back port
    .dec_src1, .dec_src2,
    .src1_value, .src2_value
  );

  alu_execute u_execute (
    .clock, .reset, .en,
    .dec_valid, .dec_op, .dec_word, .dec_use_imm, .dec_dest, .dec_imm,
    .src1_value, .src2_value,
    .ex_valid, .ex_dest, .ex_word, .ex_value
  );

  cdb_result u_result (
    .clock, .reset, .en,
    .ex_valid, .ex_dest, .ex_word, .ex_value,
    .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

`default_nettype wire

// ==== dv/prf_core_tb.sv ====
// ##########################################################################
// testbench for the physical register file datapath
// random issue stream against a register model, checked by assertions
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

`include "prf_config.svh"

module prf_core_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int N_RAND       = 300;  // random ops
  localparam int N_DIRECTED   = 12;
  localparam int MAX_STALLS   = 120;
  localparam int LIMIT_CYCLES = (N_DIRECTED + N_RAND) * 3 + MAX_STALLS + 60;

  logic                 clock;
  logic                 reset;
  logic                 en;
  logic                 issue_valid;
  prf_pkg::issue_word_u issue_word;
  logic                 cdb_valid;
  logic [`TAG_W-1:0]    cdb_tag;
  logic [`XLEN-1:0]     cdb_value;

  logic [`XLEN-1:0]        model_pr [`NUM_PR];  // register state as seen at issue
  logic [`TAG_W+`XLEN-1:0] exp_q [$];           // {tag, value} in issue order
  int                      accept_q [$];        // enabled-edge index per accepted word
  logic                    head_valid;
  logic [`TAG_W-1:0]       head_tag;
  logic [`XLEN-1:0]        head_value;
  int                      head_issue;
  int                      edge_count;          // enabled edges so far
  logic                    prev_valid;          // last enabled slot carried an issue
  logic [`TAG_W-1:0]       prev_dest;
  int                      issued;
  int                      broadcasts;
  int                      stalls;
  int                      mismatch_count;
  int                      other_count;

  prf_core_top uut (
    .clock, .reset, .en, .issue_valid, .issue_word,
    .cdb_valid, .cdb_tag, .cdb_value
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [`XLEN-1:0] model_alu(input prf_pkg::alu_op_t op, input logic word,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] full;
    int               sh;
    sh   = word ? int'(b[4:0]) : int'(b[5:0]);  // word shifts use 5 bits
    full = '0;
    case (op)
      prf_pkg::ALU_ADD: full = a + b;
      prf_pkg::ALU_SUB: full = a - b;
      prf_pkg::ALU_AND: full = a & b;
      prf_pkg::ALU_OR:  full = a | b;
      prf_pkg::ALU_XOR: full = a ^ b;
      prf_pkg::ALU_SLT: full[0] = $signed(a) < $signed(b);  // full-width compare
      prf_pkg::ALU_SLL: full = a << sh;
      prf_pkg::ALU_SRL: full = word ? {{(`XLEN-32){1'b0}}, a[31:0] >> sh} : a >> sh;
      default:          full = '0;
    endcase
    return word ? {{(`XLEN-32){full[31]}}, full[31:0]} : full;
  endfunction

  // any tag except the one produced in the previous enabled slot
  function automatic logic [`TAG_W-1:0] pick_source();
    logic [31:0] r;
    r = $urandom();
    while (prev_valid && r[`TAG_W-1:0] == prev_dest) r = $urandom();
    return r[`TAG_W-1:0];
  endfunction

  task automatic issue_op(input prf_pkg::alu_op_t op, input logic is_imm, input logic word,
                          input logic [`TAG_W-1:0] dest, input logic [`TAG_W-1:0] src1,
                          input logic [`TAG_W-1:0] src2, input logic [15:0] imm);
    prf_pkg::issue_word_u w;
    logic [`XLEN-1:0]     b;
    logic [`XLEN-1:0]     result;
    w = '0;
    w.reg_form.op     = op;
    w.reg_form.is_imm = is_imm;
    w.reg_form.word   = word;
    w.reg_form.dest   = dest;
    w.reg_form.src1   = src1;
    if (is_imm) begin
      w.imm_form.imm = imm;  // overlays src2
    end else begin
      w.reg_form.src2 = src2;
    end
    b      = is_imm ? {{(`XLEN-16){imm[15]}}, imm} : model_pr[src2];
    result = model_alu(op, word, model_pr[src1], b);
    if (dest != `TAG_W'(`ZERO_PR)) model_pr[dest] = result;  // tag 31 stays zero
    exp_q.push_back({dest, result});  // broadcast still carries the value
    @(posedge clock);
    en          <= 1'b1;
    issue_valid <= 1'b1;
    issue_word  <= w;
    prev_valid = 1'b1;
    prev_dest  = dest;
    issued++;
  endtask

  task automatic idle_slot(input logic en_v, input logic valid_v);
    logic [31:0] junk;
    junk = $urandom();
    @(posedge clock);
    en          <= en_v;
    issue_valid <= valid_v;  // stray strobe dropped while stalled
    issue_word  <= junk;
    if (en_v) prev_valid = 1'b0;
    else stalls++;
  endtask

  initial begin
    logic [31:0]       r;
    logic [`TAG_W-1:0] s1;
    logic [`TAG_W-1:0] s2;
    void'($urandom(32'h1569_6488));
    reset          = 1'b1;
    en             = 1'b0;
    issue_valid    = 1'b0;
    issue_word     = '0;
    head_valid     = 1'b0;
    prev_valid     = 1'b0;
    prev_dest      = '0;
    edge_count     = 0;
    issued         = 0;
    broadcasts     = 0;
    stalls         = 0;
    mismatch_count = 0;
    other_count    = 0;
    for (int i = 0; i < `NUM_PR; i++) model_pr[i] = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    // untouched registers read zero
    issue_op(prf_pkg::ALU_ADD, 1'b0, 1'b0, 5'd1, 5'd10, 5'd31, 16'h0);
    issue_op(prf_pkg::ALU_OR, 1'b0, 1'b1, 5'd2, 5'd20, 5'd30, 16'h0);
    // write to tag 31 shows on the bus, then reads back as zero
    issue_op(prf_pkg::ALU_ADD, 1'b1, 1'b0, 5'd31, 5'd0, 5'd0, 16'h7abc);
    idle_slot(1'b1, 1'b0);
    issue_op(prf_pkg::ALU_ADD, 1'b0, 1'b0, 5'd7, 5'd31, 5'd31, 16'h0);
    issue_op(prf_pkg::ALU_XOR, 1'b1, 1'b0, 5'd8, 5'd31, 5'd0, 16'hffff);
    // consumers two enabled cycles behind their producers
    issue_op(prf_pkg::ALU_ADD, 1'b1, 1'b0, 5'd5, 5'd31, 5'd0, 16'h1234);
    idle_slot(1'b1, 1'b0);
    issue_op(prf_pkg::ALU_ADD, 1'b0, 1'b0, 5'd6, 5'd5, 5'd5, 16'h0);
    issue_op(prf_pkg::ALU_SLL, 1'b1, 1'b1, 5'd9, 5'd8, 5'd0, 16'h0024);
    issue_op(prf_pkg::ALU_SRL, 1'b0, 1'b1, 5'd10, 5'd6, 5'd5, 16'h0);
    for (int i = 0; i < N_RAND; i++) begin
      r = $urandom();
      if (stalls < MAX_STALLS && r[2:0] == 3'd0) idle_slot(1'b0, r[3]);
      if (r[6:4] == 3'd0) idle_slot(1'b1, 1'b0);  // enabled bubble
      s1 = pick_source();
      s2 = pick_source();
      r  = $urandom();
      issue_op(prf_pkg::alu_op_t'({1'b0, r[2:0]}), r[3], r[4], r[9:5], s1, s2, r[31:16]);
    end
    idle_slot(1'b1, 1'b0);
    while (exp_q.size() != 0) idle_slot(1'b1, 1'b0);  // drain the pipe
    repeat (3) idle_slot(1'b1, 1'b0);
    a_all_broadcast: assert (broadcasts == issued)
      else begin
        other_count++;
        $display("broadcast count %0d does not match issue count %0d", broadcasts, issued);
      end
    $display("errors: %0d mismatches, %0d other failures (%0d ops, %0d stall cycles)",
             mismatch_count, other_count, issued, stalls);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // accepted words and write-backs as seen at the dut
  always @(posedge clock) begin
    if (!reset) begin
      if (en && issue_valid) accept_q.push_back(edge_count);
      if (en && cdb_valid) begin
        broadcasts++;
        if (accept_q.size() != 0) begin
          void'(accept_q.pop_front());
          void'(exp_q.pop_front());
        end
      end
      if (en) edge_count++;
    end
  end

  always @(negedge clock) begin
    head_valid = accept_q.size() != 0;
    if (head_valid) begin
      head_issue = accept_q[0];
      {head_tag, head_value} = exp_q[0];
    end
  end

  a_reset_idle: assert property (@(posedge clock) reset |=> !cdb_valid)
    else begin
      other_count++;
      $display("cdb_valid high right after a reset cycle at %0t", $time);
    end

  a_outstanding: assert property (@(posedge clock) disable iff (reset)
      (en && cdb_valid) |-> head_valid)
    else begin
      other_count++;
      $display("broadcast at %0t with no instruction outstanding", $time);
    end

  a_cdb_tag: assert property (@(posedge clock) disable iff (reset)
      (en && cdb_valid && head_valid) |-> cdb_tag == head_tag)
    else begin
      mismatch_count++;
      $display("mismatch at %0t: cdb_tag expected %0d actual %0d",
               $time, $sampled(head_tag), $sampled(cdb_tag));
    end

  a_cdb_value: assert property (@(posedge clock) disable iff (reset)
      (en && cdb_valid && head_valid) |-> cdb_value == head_value)
    else begin
      mismatch_count++;
      $display("mismatch at %0t: cdb_value expected %h actual %h",
               $time, $sampled(head_value), $sampled(cdb_value));
    end

  a_latency: assert property (@(posedge clock) disable iff (reset)
      (en && cdb_valid && head_valid) |-> edge_count - head_issue == 3)
    else begin
      mismatch_count++;
      $display("mismatch at %0t: issue-to-cdb enabled cycles expected 3 actual %0d",
               $time, $sampled(edge_count - head_issue));
    end

  a_stall_hold: assert property (@(posedge clock) disable iff (reset) !en |=> $stable(cdb_valid))
    else begin
      other_count++;
      $display("cdb_valid changed across a stall cycle at %0t", $time);
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
source/prf_pkg.sv
source/issue_decode.sv
source/phys_regfile.sv
source/alu_execute.sv
source/cdb_result.sv
source/prf_core_top.sv
dv/prf_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the physical register file testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module prf_core_tb -f all.f -o prf_core_sim
./obj_dir/prf_core_sim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation passed"
